// ==== design/enigmaPkg.sv ====
// shared definitions for the two-rotor cipher
//   symbol width, rotor depth, load length
//   rotor B group permutation table
//   symbol type and its step-selector view
`default_nettype none

package enigmaPkg;

	localparam int symbolWidth = 6;
	localparam int rotorDepth = 64;
	localparam int loadLength = 128;
	localparam int groupSize = 8;

	// destination slot inside a group, per selector and source slot
	localparam logic [2:0] permTable [0:groupSize-1][0:groupSize-1] = '{
		'{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7},
		'{3'd1, 3'd0, 3'd3, 3'd2, 3'd5, 3'd4, 3'd7, 3'd6},
		'{3'd2, 3'd3, 3'd0, 3'd1, 3'd6, 3'd7, 3'd4, 3'd5},
		'{3'd0, 3'd4, 3'd5, 3'd6, 3'd1, 3'd2, 3'd3, 3'd7},
		'{3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd1, 3'd2, 3'd3},
		'{3'd5, 3'd6, 3'd7, 3'd3, 3'd4, 3'd0, 3'd1, 3'd2},
		'{3'd6, 3'd7, 3'd3, 3'd2, 3'd5, 3'd4, 3'd0, 3'd1},
		'{3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0}
	};

	typedef logic [symbolWidth-1:0] symbol_t;

	// one symbol, read either as a table index or as a step selector
	// rotor A only looks at the low two bits of stepSel
	typedef union packed {
		symbol_t whole;
		struct packed {
			logic [2:0] upper;
			logic [2:0] stepSel;
		} parts;
	} symbolView_u;

endpackage

`default_nettype wire

// ==== design/rotorCtrlIf.sv ====
// control bundle from the sequencer to both rotors
//   load strobe, address and word, captured mode, step strobe
`timescale 1ns/100ps
`default_nettype none

interface rotorCtrlIf import enigmaPkg::*; ();

	logic loadEn;
	// msb picks rotor B, low bits give the slot
	logic [$clog2(loadLength)-1:0] loadAddr;
	symbol_t loadCode;
	logic decrypt;
	logic step;

	modport sequencer (
		output loadEn, loadAddr, loadCode, decrypt, step
	);

	modport rotor (
		input loadEn, loadAddr, loadCode, decrypt, step
	);

endinterface

`default_nettype wire

// ==== design/cipherSequencer.sv ====
// cipher sequencer
//   load counter and mode capture at the start of a load
//   code input register with its valid bit
//   output register for the transformed symbol
`timescale 1ns/100ps
`default_nettype none

module cipherSequencer import enigmaPkg::*; (
	input logic clk,
	input logic rst_n,
	input logic inValid,
	input logic codeValid,
	input logic cryptMode,
	input symbol_t code,
	input symbol_t result,
	rotorCtrlIf.sequencer ctrl,
	output symbol_t codeQ,
	output logic outValid,
	output symbol_t outCode
);

	logic [$clog2(loadLength)-1:0] loadCnt;
	logic inValidQ;
	logic decryptQ;
	logic codeValidQ;

	// ##################################################
	// load phase

	// 7-bit counter wraps at 128 on its own
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			loadCnt <= '0;
		end else if (inValid) begin
			loadCnt <= loadCnt + 1'b1;
		end else begin
			loadCnt <= '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inValidQ <= 1'b0;
			decryptQ <= 1'b0;
		end else begin
			inValidQ <= inValid;
			// mode only counts on the first word of a load
			if (inValid && !inValidQ) begin
				decryptQ <= cryptMode;
			end
		end
	end

	assign ctrl.loadEn = inValid;
	assign ctrl.loadAddr = loadCnt;
	assign ctrl.loadCode = code;
	assign ctrl.decrypt = decryptQ;

	// ##################################################
	// code phase

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			codeQ <= '0;
			codeValidQ <= 1'b0;
		end else begin
			codeValidQ <= codeValid;
			if (codeValid) begin
				codeQ <= code;
			end
		end
	end

	// rotors step on the same edge that captures the result
	assign ctrl.step = codeValidQ;

	// outCode held at zero between symbols
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outValid <= 1'b0;
			outCode <= '0;
		end else begin
			outValid <= codeValidQ;
			outCode <= codeValidQ ? result : '0;
		end
	end

	// load and code phases never overlap on the inputs
	noLoadDuringCode: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(inValid && codeValid)
	) else $error("inValid and codeValid high together");

endmodule

`default_nettype wire

// ==== design/shiftRotor.sv ====
// rotor A
//   64-entry storage, loaded from the first half of a load
//   forward lookup and reverse search
//   right rotation by 0..3 after each symbol
`timescale 1ns/100ps
`default_nettype none

module shiftRotor import enigmaPkg::*; (
	input logic clk,
	input logic rst_n,
	rotorCtrlIf.rotor ctrl,
	input symbol_t codeQ,
	input symbol_t backB,
	output symbol_t fwdA,
	output symbol_t result
);

	symbol_t rotor [rotorDepth];
	symbol_t rotated [rotorDepth];
	symbolView_u stepView;
	logic [1:0] shiftAmt;
	logic loadHere;

	// rotor A owns the lower half of the load address space
	assign loadHere = ctrl.loadEn && !ctrl.loadAddr[$clog2(loadLength)-1];

	// ##################################################
	// lookups

	assign fwdA = rotor[codeQ];

	// inverse: slot holding backB
	always_comb begin
		result = '0;
		for (int i = 0; i < rotorDepth; i++) begin
			if (rotor[i] == backB) begin
				result = symbol_t'(i);
			end
		end
	end

	// ##################################################
	// stepping

	// encrypt steps on our own output, decrypt on rotor B's inverse
	assign stepView.whole = ctrl.decrypt ? backB : fwdA;
	assign shiftAmt = stepView.parts.stepSel[1:0];

	always_comb begin
		symbol_t src;
		for (int i = 0; i < rotorDepth; i++) begin
			// 6-bit subtraction wraps around the rotor
			src = symbol_t'(i) - symbol_t'(shiftAmt);
			rotated[i] = rotor[src];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rotorDepth; i++) begin
				rotor[i] <= '0;
			end
		end else if (loadHere) begin
			rotor[ctrl.loadAddr[symbolWidth-1:0]] <= ctrl.loadCode;
		end else if (ctrl.step) begin
			rotor <= rotated;
		end
	end

	// a symbol in flight must not meet a load word
	noStepDuringLoad: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(ctrl.step && ctrl.loadEn)
	) else $error("rotor step and load in the same cycle");

endmodule

`default_nettype wire

// ==== design/permuteRotor.sv ====
// rotor B and reflector
//   64-entry storage, loaded from the second half of a load
//   forward lookup, reflector, reverse search
//   per-group permutation after each symbol
`timescale 1ns/100ps
`default_nettype none

module permuteRotor import enigmaPkg::*; (
	input logic clk,
	input logic rst_n,
	rotorCtrlIf.rotor ctrl,
	input symbol_t fwdA,
	output symbol_t backB
);

	symbol_t rotor [rotorDepth];
	symbol_t permuted [rotorDepth];
	symbol_t fwdB;
	symbol_t reflect;
	symbolView_u selView;
	logic [2:0] permSel;
	logic invHit;
	logic loadHere;

	// upper half of the load goes here
	assign loadHere = ctrl.loadEn && ctrl.loadAddr[$clog2(loadLength)-1];

	// ##################################################
	// forward, reflector, inverse

	assign fwdB = rotor[fwdA];
	assign reflect = symbol_t'(rotorDepth - 1) - fwdB;

	always_comb begin
		backB = '0;
		invHit = 1'b0;
		for (int i = 0; i < rotorDepth; i++) begin
			if (rotor[i] == reflect) begin
				backB = symbol_t'(i);
				invHit = 1'b1;
			end
		end
	end

	// ##################################################
	// group permutation

	// selector source flips with the mode
	assign selView.whole = ctrl.decrypt ? reflect : fwdB;
	assign permSel = selView.parts.stepSel;

	always_comb begin
		int dst;
		// every slot gets overwritten, patterns are all bijections
		permuted = rotor;
		for (int g = 0; g < rotorDepth / groupSize; g++) begin
			for (int s = 0; s < groupSize; s++) begin
				dst = g * groupSize + int'(permTable[permSel][s]);
				permuted[dst] = rotor[g * groupSize + s];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rotorDepth; i++) begin
				rotor[i] <= '0;
			end
		end else if (loadHere) begin
			rotor[ctrl.loadAddr[symbolWidth-1:0]] <= ctrl.loadCode;
		end else if (ctrl.step) begin
			rotor <= permuted;
		end
	end

	// only holds if the loaded rotor B was a permutation
	inverseHit: assert property (
		@(posedge clk) disable iff (!rst_n)
		ctrl.step |-> invHit
	) else $error("rotor B inverse lookup found no entry");

endmodule

`default_nettype wire

// ==== design/enigmaTop.sv ====
// cipher top level
//   plain ports to the outside
//   sequencer, rotor A, rotor B and their control interface
`timescale 1ns/100ps
`default_nettype none

module enigmaTop import enigmaPkg::*; (
	input logic clk,
	input logic rst_n,
	input logic inValid,
	input logic codeValid,
	input logic cryptMode,
	input logic [5:0] code,
	output logic outValid,
	output logic [5:0] outCode
);

	symbol_t codeQ;
	symbol_t fwdA;
	symbol_t backB;
	symbol_t result;

	rotorCtrlIf ctrl ();

	cipherSequencer sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.inValid(inValid),
		.codeValid(codeValid),
		.cryptMode(cryptMode),
		.code(code),
		.result(result),
		.ctrl(ctrl.sequencer),
		.codeQ(codeQ),
		.outValid(outValid),
		.outCode(outCode)
	);

	// forward through A, back out through A
	shiftRotor rotorA (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl.rotor),
		.codeQ(codeQ),
		.backB(backB),
		.fwdA(fwdA),
		.result(result)
	);

	// B plus the reflector
	permuteRotor rotorB (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl.rotor),
		.fwdA(fwdA),
		.backB(backB)
	);

endmodule

`default_nettype wire

// ==== tests/enigmaModel.svh ====
// reference model of the two-rotor cipher
//   model copies of rotor A and rotor B, captured mode
//   group permutation destinations
//   inverse searches, symbol transform, rotor stepping
`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

symbol_t modelA [rotorDepth];
symbol_t modelB [rotorDepth];
logic modelDecrypt;

// destination slot within a group of eight
function automatic logic [2:0] groupDest(input logic [2:0] sel, input logic [2:0] src);
	// listed from source slot 7 down to source slot 0
	logic [23:0] pat3 = {3'd7, 3'd3, 3'd2, 3'd1, 3'd6, 3'd5, 3'd4, 3'd0};
	logic [23:0] pat5 = {3'd2, 3'd1, 3'd0, 3'd4, 3'd3, 3'd7, 3'd6, 3'd5};
	logic [23:0] pat6 = {3'd1, 3'd0, 3'd4, 3'd5, 3'd2, 3'd3, 3'd7, 3'd6};
	case (sel)
		3'd0: return src;
		3'd1: return src ^ 3'd1;
		3'd2: return src ^ 3'd2;
		3'd3: return pat3[src * 3 +: 3];
		3'd4: return src ^ 3'd4;
		3'd5: return pat5[src * 3 +: 3];
		3'd6: return pat6[src * 3 +: 3];
		default: return 3'd7 - src;
	endcase
endfunction

function automatic symbol_t slotOfA(input symbol_t value);
	for (int i = 0; i < rotorDepth; i++) begin
		if (modelA[i] == value) begin
			return symbol_t'(i);
		end
	end
	return '0;
endfunction

function automatic symbol_t slotOfB(input symbol_t value);
	for (int i = 0; i < rotorDepth; i++) begin
		if (modelB[i] == value) begin
			return symbol_t'(i);
		end
	end
	return '0;
endfunction

// rotate A right, shuffle B inside each group
function automatic void stepRotors(input logic [1:0] amt, input logic [2:0] sel);
	symbol_t oldA [rotorDepth];
	symbol_t oldB [rotorDepth];
	int shift;
	int dst;
	oldA = modelA;
	oldB = modelB;
	shift = amt;
	for (int i = 0; i < rotorDepth; i++) begin
		modelA[i] = oldA[(i - shift + rotorDepth) % rotorDepth];
	end
	for (int g = 0; g < rotorDepth / groupSize; g++) begin
		for (int s = 0; s < groupSize; s++) begin
			dst = g * groupSize + int'(groupDest(sel, 3'(s)));
			modelB[dst] = oldB[g * groupSize + s];
		end
	end
endfunction

// five stages, then the rotors move on
function automatic symbol_t cipherSymbol(input symbol_t sym);
	symbol_t fwdA;
	symbol_t fwdB;
	symbol_t refl;
	symbol_t backB;
	symbol_t res;
	fwdA = modelA[sym];
	fwdB = modelB[fwdA];
	refl = 6'd63 - fwdB;
	backB = slotOfB(refl);
	res = slotOfA(backB);
	if (modelDecrypt) begin
		stepRotors(backB[1:0], refl[2:0]);
	end else begin
		stepRotors(fwdA[1:0], fwdB[2:0]);
	end
	return res;
endfunction

`endif

// ==== tests/enigmaTb.sv ====
// testbench for the two-rotor cipher
//   clock, reset, load and symbol stimulus on the falling edge
//   random rotor permutations from an xorshift source
//   comparator against the reference model, watchdog
`timescale 1ns/100ps
`default_nettype none

module enigmaTb import enigmaPkg::*; ();

	logic clk;
	logic rst_n;
	logic inValid;
	logic codeValid;
	logic cryptMode;
	logic [5:0] code;
	logic outValid;
	logic [5:0] outCode;

	logic [31:0] rngState;
	int cycleCnt = 0;
	int passCount = 0;
	int failCount = 0;
	symbol_t expCode [$];
	int expCycle [$];
	symbol_t newA [rotorDepth];
	symbol_t newB [rotorDepth];
	symbol_t savedA [rotorDepth];
	symbol_t savedB [rotorDepth];

	`include "enigmaModel.svh"

	enigmaTop uut (
		.clk(clk),
		.rst_n(rst_n),
		.inValid(inValid),
		.codeValid(codeValid),
		.cryptMode(cryptMode),
		.code(code),
		.outValid(outValid),
		.outCode(outCode)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
	end

	// ##################################################
	// random source and stimulus helpers

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Fisher-Yates over 0..63 for both rotors
	task automatic makeRotors();
		int j;
		symbol_t tmp;
		for (int i = 0; i < rotorDepth; i++) begin
			newA[i] = symbol_t'(i);
			newB[i] = symbol_t'(i);
		end
		for (int i = rotorDepth - 1; i > 0; i--) begin
			j = nextRandom() % (i + 1);
			tmp = newA[i];
			newA[i] = newA[j];
			newA[j] = tmp;
		end
		for (int i = rotorDepth - 1; i > 0; i--) begin
			j = nextRandom() % (i + 1);
			tmp = newB[i];
			newB[i] = newB[j];
			newB[j] = tmp;
		end
	endtask

	task automatic loadRotors(input logic mode);
		// let the last symbol step before the load starts
		repeat (2) @(negedge clk);
		for (int k = 0; k < loadLength; k++) begin
			inValid = 1'b1;
			// flipped after the first word, must be ignored
			cryptMode = (k == 0) ? mode : ~mode;
			code = (k < rotorDepth) ? newA[k] : newB[k - rotorDepth];
			@(negedge clk);
		end
		inValid = 1'b0;
		cryptMode = 1'b0;
		code = '0;
		modelA = newA;
		modelB = newB;
		modelDecrypt = mode;
	endtask

	task automatic sendSymbol(input symbol_t sym);
		codeValid = 1'b1;
		code = sym;
		expCode.push_back(cipherSymbol(sym));
		// sampled at the next edge, registered one edge later
		expCycle.push_back(cycleCnt + 2);
		@(negedge clk);
		codeValid = 1'b0;
		code = '0;
	endtask

	task automatic drainOutputs();
		while (expCode.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic reportTest(input int num, input string name, input int failBefore);
		$display("test %0d %s: %s", num, name, (failCount == failBefore) ? "pass" : "FAIL");
	endtask

	// ##################################################
	// comparator

	initial begin
		@(posedge rst_n);
		forever begin
			@(negedge clk);
			if (outValid) begin
				assert (expCode.size() > 0)
				else begin
					failCount++;
					$display("output seen at %0t with no symbol pending", $time);
				end
				if (expCode.size() > 0) begin
					assert (outCode === expCode[0]) passCount++;
					else begin
						failCount++;
						$display("[ERROR] %0t: outCode %0d, expected %0d",
							$time, outCode, expCode[0]);
					end
					assert (cycleCnt == expCycle[0]) passCount++;
					else begin
						failCount++;
						$display("[ERROR] %0t: output in cycle %0d, expected cycle %0d",
							$time, cycleCnt, expCycle[0]);
					end
					void'(expCode.pop_front());
					void'(expCycle.pop_front());
				end
			end else begin
				assert (outCode === '0) passCount++;
				else begin
					failCount++;
					$display("[ERROR] %0t: outCode %0d while outValid is low", $time, outCode);
				end
			end
		end
	end

	// ##################################################
	// test sequence

	initial begin
		int failBefore;
		int gap;
		rst_n = 1'b0;
		inValid = 1'b0;
		codeValid = 1'b0;
		cryptMode = 1'b0;
		code = '0;
		rngState = 32'd29;
		modelDecrypt = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		failBefore = failCount;
		repeat (4) begin
			@(negedge clk);
			assert (outValid === 1'b0 && outCode === '0) passCount++;
			else begin
				failCount++;
				$display("[ERROR] %0t: output active after reset before any load", $time);
			end
		end
		reportTest(1, "reset state", failBefore);

		failBefore = failCount;
		makeRotors();
		savedA = newA;
		savedB = newB;
		loadRotors(1'b0);
		for (int i = 0; i < 40; i++) begin
			sendSymbol(symbol_t'(nextRandom()));
		end
		drainOutputs();
		reportTest(2, "encrypt back-to-back", failBefore);

		// same starting rotors, other stepping sources
		failBefore = failCount;
		newA = savedA;
		newB = savedB;
		loadRotors(1'b1);
		for (int i = 0; i < 40; i++) begin
			sendSymbol(symbol_t'(nextRandom()));
		end
		drainOutputs();
		reportTest(3, "decrypt back-to-back", failBefore);

		// rotors carry on from test 3
		failBefore = failCount;
		for (int i = 0; i < 40; i++) begin
			sendSymbol(symbol_t'(nextRandom()));
			gap = nextRandom() % 4;
			repeat (gap) @(negedge clk);
		end
		drainOutputs();
		reportTest(4, "gapped input", failBefore);

		failBefore = failCount;
		makeRotors();
		loadRotors(1'b0);
		for (int i = 0; i < 40; i++) begin
			sendSymbol(symbol_t'(nextRandom()));
		end
		drainOutputs();
		reportTest(5, "reload with mode change", failBefore);

		$display("checks passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// ##################################################
	// watchdog

	initial begin
		int limit;
		// reset, three loads, three dense runs, one gapped run, margin
		limit = 16 + 3 * (loadLength + 4) + 3 * (40 + 4) + 40 * 5 + 200;
		#(limit * 20);
		$display("timeout: run still going after %0d clock cycles", limit);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tests
design/enigmaPkg.sv
design/rotorCtrlIf.sv
design/cipherSequencer.sv
design/shiftRotor.sv
design/permuteRotor.sv
design/enigmaTop.sv
tests/enigmaTb.sv
